// ==== source/pio_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// PIO shared definitions
// Data types, opcode encodings and the MOV bit operation
//////////////////////////////////////////////////////////////////////
package pio_pkg;

  parameter int PINS = 32;  // Number of GPIOs

  typedef logic [PINS-1:0] word_t;
  typedef logic [15:0]     instr_t;
  typedef logic [4:0]      addr_t;
  typedef logic [5:0]      shift_count_t;  // 0 to 32

  typedef enum logic [2:0] {
    op_jmp,
    op_wait,
    op_in,
    op_out,
    op_push_pull,
    op_mov,
    op_irq,
    op_set
  } opcode_e;

  typedef enum logic [1:0] {
    bop_none,
    bop_invert,
    bop_reverse,
    bop_reserved
  } bit_op_e;

  function automatic word_t apply_bit_op(word_t value, bit_op_e bop);
    word_t reversed;
    for (int i = 0; i < PINS; i++) begin
      reversed[i] = value[PINS-1-i];
    end
    case (bop)
      bop_invert:  return ~value;
      bop_reverse: return reversed;
      default:     return value;  // Reserved acts as none
    endcase
  endfunction

endpackage

// ==== source/pio_clock_divider.sv ====
//////////////////////////////////////////////////////////////////////
// Integer clock divider, one tick every div_int clocks
//////////////////////////////////////////////////////////////////////
module pio_clock_divider (
  input  logic        clk,
  input  logic        reset,
  input  logic        en,
  input  logic [15:0] div_int,
  output logic        tick
);

  logic [15:0] count;  // Clocks left until the next tick

  assign tick = en && (count == 16'd1);

  // A reload of 0 wraps through 65535, giving a period of 65536
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= div_int;
    end else if (en) begin
      if (tick) begin
        count <= div_int;
      end else begin
        count <= count - 16'd1;
      end
    end
  end

endmodule

// ==== source/pio_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// PIO sequencer
// Decodes instructions, runs pc, delay and stall, strobes datapath
//////////////////////////////////////////////////////////////////////
module pio_sequencer import pio_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         en,
  input  logic         tick,
  input  instr_t       instr,
  input  word_t        input_pins,
  input  logic         empty,
  input  logic         full,
  input  word_t        din,
  input  addr_t        wrap_target,
  input  addr_t        wrap_top,
  input  addr_t        jmp_pin,
  input  addr_t        pins_in_base,
  input  logic [4:0]   osr_threshold,
  input  word_t        x,
  input  word_t        y,
  input  word_t        isr,
  input  word_t        osr,
  input  word_t        osr_out,
  input  shift_count_t osr_count,
  output addr_t        pc,
  output logic         push,
  output logic         pull,
  output logic         exec_stalled,
  output logic         x_load,
  output logic         y_load,
  output logic         x_dec,
  output logic         y_dec,
  output word_t        scratch_value,
  output logic         isr_load,
  output logic         isr_shift,
  output word_t        isr_value,
  output logic         osr_load,
  output logic         osr_shift,
  output word_t        osr_value,
  output logic [4:0]   shift_amount,
  output logic         set_pins,
  output logic         set_dirs,
  output logic         out_pins,
  output logic         out_dirs,
  output word_t        pin_value
);

  opcode_e      op;
  logic [4:0]   delay;
  logic [2:0]   op1;
  logic [4:0]   op2;
  logic         step;
  logic         waiting;
  logic         jmp;
  addr_t        jmp_addr;
  logic [4:0]   delay_cnt;
  logic [63:0]  in_pins_rot;
  word_t        in_pins;
  logic [2:0]   src_sel;
  word_t        src_word;
  word_t        mov_value;
  shift_count_t osr_threshold_wide;

  assign op    = opcode_e'(instr[15:13]);
  assign delay = instr[12:8];
  assign op1   = instr[7:5];
  assign op2   = instr[4:0];

  assign step         = en && tick && (delay_cnt == 5'd0);
  assign shift_amount = op2;  // Bit count of IN and OUT

  assign in_pins_rot = {input_pins, input_pins} >> pins_in_base;
  assign in_pins     = in_pins_rot[31:0];

  assign osr_threshold_wide = (osr_threshold == 5'd0) ? 6'd32 : {1'b0, osr_threshold};

  // IN and MOV share the source encoding
  assign src_sel = (op == op_in) ? op1 : op2[2:0];

  always_comb begin
    case (src_sel)
      3'd0:    src_word = in_pins;
      3'd1:    src_word = x;
      3'd2:    src_word = y;
      3'd6:    src_word = isr;
      3'd7:    src_word = osr;
      default: src_word = '0;  // Null
    endcase
  end

  assign mov_value = apply_bit_op(src_word, bit_op_e'(op2[4:3]));

  always_comb begin
    waiting       = 1'b0;
    jmp           = 1'b0;
    jmp_addr      = op2;
    push          = 1'b0;
    pull          = 1'b0;
    x_load        = 1'b0;
    y_load        = 1'b0;
    x_dec         = 1'b0;
    y_dec         = 1'b0;
    scratch_value = osr_out;
    isr_load      = 1'b0;
    isr_shift     = 1'b0;
    isr_value     = src_word;
    osr_load      = 1'b0;
    osr_shift     = 1'b0;
    osr_value     = din;
    set_pins      = 1'b0;
    set_dirs      = 1'b0;
    out_pins      = 1'b0;
    out_dirs      = 1'b0;
    pin_value     = osr_out;
    if (step) begin
      case (op)
        op_jmp: begin
          case (op1)
            3'd0: jmp = 1'b1;
            3'd1: jmp = (x == '0);
            3'd2: begin
              jmp   = (x != '0);  // Test before the decrement
              x_dec = 1'b1;
            end
            3'd3: jmp = (y == '0);
            3'd4: begin
              jmp   = (y != '0);
              y_dec = 1'b1;
            end
            3'd5: jmp = (x != y);
            3'd6: jmp = input_pins[jmp_pin];
            default: jmp = (osr_count < osr_threshold_wide);  // !OSRE
          endcase
        end
        op_wait: begin
          case (op1[1:0])
            2'd0:    waiting = (input_pins[op2] != op1[2]);
            2'd1:    waiting = (in_pins[op2] != op1[2]);  // Relative to pins_in_base
            default: waiting = 1'b0;                      // IRQ wait never blocks
          endcase
        end
        op_in: isr_shift = 1'b1;
        op_out: begin
          osr_shift = 1'b1;
          isr_value = osr_out;
          jmp_addr  = osr_out[4:0];
          case (op1)
            3'd0:    out_pins = 1'b1;
            3'd1:    x_load   = 1'b1;
            3'd2:    y_load   = 1'b1;
            3'd4:    out_dirs = 1'b1;
            3'd5:    jmp      = 1'b1;
            3'd6:    isr_load = 1'b1;
            default: ;  // Null
          endcase
        end
        op_push_pull: begin
          if (!op1[2]) begin
            waiting   = op1[0] && full;
            push      = !waiting;
            isr_load  = !waiting;  // Push clears the ISR
            isr_value = '0;
          end else begin
            waiting   = op1[0] && empty;
            pull      = !empty;
            osr_load  = !waiting;
            osr_value = empty ? x : din;  // Non-blocking on empty takes X
          end
        end
        op_mov: begin
          scratch_value = mov_value;
          isr_value     = mov_value;
          osr_value     = mov_value;
          pin_value     = mov_value;
          jmp_addr      = mov_value[4:0];
          case (op1)
            3'd0:    out_pins = 1'b1;
            3'd1:    x_load   = 1'b1;
            3'd2:    y_load   = 1'b1;
            3'd5:    jmp      = 1'b1;
            3'd6:    isr_load = 1'b1;
            3'd7:    osr_load = 1'b1;
            default: ;
          endcase
        end
        op_set: begin
          scratch_value = {27'b0, op2};
          pin_value     = {27'b0, op2};
          case (op1)
            3'd0:    set_pins = 1'b1;
            3'd1:    x_load   = 1'b1;
            3'd2:    y_load   = 1'b1;
            3'd4:    set_dirs = 1'b1;
            default: ;
          endcase
        end
        default: ;  // IRQ executes as a no-op
      endcase
    end
  end

  // Delay counts only after the stall clears
  always_ff @(posedge clk) begin
    if (reset) begin
      pc           <= '0;
      delay_cnt    <= '0;
      exec_stalled <= 1'b0;
    end else if (en && tick) begin
      if (delay_cnt != 5'd0) begin
        delay_cnt <= delay_cnt - 5'd1;
      end else begin
        exec_stalled <= waiting;
        if (!waiting) begin
          delay_cnt <= delay;
          if (jmp) begin
            pc <= jmp_addr;
          end else if (pc == wrap_top) begin
            pc <= wrap_target;
          end else begin
            pc <= pc + 5'd1;
          end
        end
      end
    end
  end

endmodule

// ==== source/pio_scratch_regs.sv ====
//////////////////////////////////////////////////////////////////////
// X and Y scratch registers with load and post-decrement
//////////////////////////////////////////////////////////////////////
module pio_scratch_regs import pio_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  x_load,
  input  logic  y_load,
  input  logic  x_dec,
  input  logic  y_dec,
  input  word_t scratch_value,
  output word_t x,
  output word_t y
);

  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else begin
      if (x_load) begin
        x <= scratch_value;
      end else if (x_dec) begin
        x <= x - 1'b1;  // Wraps from 0 to all ones
      end
      if (y_load) begin
        y <= scratch_value;
      end else if (y_dec) begin
        y <= y - 1'b1;
      end
    end
  end

endmodule

// ==== source/pio_input_shift.sv ====
//////////////////////////////////////////////////////////////////////
// Input shift register
// Shifts new bits in from either side and counts them up to 32
//////////////////////////////////////////////////////////////////////
module pio_input_shift import pio_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         in_shift_dir,
  input  logic         isr_load,
  input  logic         isr_shift,
  input  logic [4:0]   shift_amount,
  input  word_t        isr_value,
  output word_t        isr,
  output shift_count_t isr_count
);

  shift_count_t amount;
  word_t        keep_mask;
  logic [6:0]   count_sum;

  assign amount    = (shift_amount == 5'd0) ? 6'd32 : {1'b0, shift_amount};
  assign keep_mask = ~({PINS{1'b1}} << amount);  // Low amount bits
  assign count_sum = isr_count + amount;

  always_ff @(posedge clk) begin
    if (isr_load) begin
      isr <= isr_value;
    end else if (isr_shift) begin
      if (in_shift_dir) begin
        isr <= (isr >> amount) | (isr_value << (6'd32 - amount));  // Enter at the MSB
      end else begin
        isr <= (isr << amount) | (isr_value & keep_mask);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || isr_load) begin
      isr_count <= '0;
    end else if (isr_shift) begin
      isr_count <= (count_sum > 7'd32) ? 6'd32 : count_sum[5:0];
    end
  end

endmodule

// ==== source/pio_output_shift.sv ====
//////////////////////////////////////////////////////////////////////
// Output shift register
// Presents the next bits at bit 0 and counts bits consumed
//////////////////////////////////////////////////////////////////////
module pio_output_shift import pio_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         out_shift_dir,
  input  logic         osr_load,
  input  logic         osr_shift,
  input  logic [4:0]   shift_amount,
  input  word_t        osr_value,
  output word_t        osr,
  output word_t        osr_out,
  output shift_count_t osr_count
);

  shift_count_t amount;
  word_t        keep_mask;
  logic [6:0]   count_sum;

  assign amount    = (shift_amount == 5'd0) ? 6'd32 : {1'b0, shift_amount};
  assign keep_mask = ~({PINS{1'b1}} << amount);
  assign count_sum = osr_count + amount;

  // Right shift takes the low bits, left shift the high bits
  assign osr_out = out_shift_dir ? (osr & keep_mask) : (osr >> (6'd32 - amount));

  always_ff @(posedge clk) begin
    if (osr_load) begin
      osr <= osr_value;
    end else if (osr_shift) begin
      if (out_shift_dir) begin
        osr <= osr >> amount;
      end else begin
        osr <= osr << amount;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      osr_count <= 6'd32;  // Reads as empty
    end else if (osr_load) begin
      osr_count <= '0;
    end else if (osr_shift) begin
      osr_count <= (count_sum > 7'd32) ? 6'd32 : count_sum[5:0];
    end
  end

endmodule

// ==== source/pio_pin_writer.sv ====
//////////////////////////////////////////////////////////////////////
// Pin output block
// Writes a window of pin values or directions, wrapping at 32
//////////////////////////////////////////////////////////////////////
module pio_pin_writer import pio_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         set_pins,
  input  logic         set_dirs,
  input  logic         out_pins,
  input  logic         out_dirs,
  input  word_t        pin_value,
  input  addr_t        pins_set_base,
  input  logic [2:0]   pins_set_count,
  input  addr_t        pins_out_base,
  input  shift_count_t pins_out_count,
  output word_t        output_pins,
  output word_t        pin_directions
);

  logic         use_set;
  addr_t        base;
  shift_count_t count;
  word_t        window;
  word_t        value_bits;
  logic [63:0]  window_rot;
  logic [63:0]  value_rot;

  assign use_set    = set_pins || set_dirs;  // SET mapping, else OUT mapping
  assign base       = use_set ? pins_set_base : pins_out_base;
  assign count      = use_set ? {3'b000, pins_set_count} : pins_out_count;
  assign window     = ~({PINS{1'b1}} << count);
  assign value_bits = pin_value & window;

  // Rotate left by base, upper half holds the result
  assign window_rot = {window, window} << base;
  assign value_rot  = {value_bits, value_bits} << base;

  always_ff @(posedge clk) begin
    if (reset) begin
      output_pins    <= '0;
      pin_directions <= '0;
    end else begin
      if (set_pins || out_pins) begin
        output_pins <= (output_pins & ~window_rot[63:32]) | value_rot[63:32];
      end
      if (set_dirs || out_dirs) begin
        pin_directions <= (pin_directions & ~window_rot[63:32]) | value_rot[63:32];
      end
    end
  end

endmodule

// ==== source/pio_machine.sv ====
//////////////////////////////////////////////////////////////////////
// PIO state machine top level
// Connects the divider, sequencer and datapath registers
//////////////////////////////////////////////////////////////////////
module pio_machine import pio_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         en,
  input  logic [15:0]  div_int,
  input  instr_t       instr,
  input  word_t        din,
  input  logic         empty,
  input  logic         full,
  input  word_t        input_pins,
  input  addr_t        wrap_target,
  input  addr_t        wrap_top,
  input  addr_t        jmp_pin,
  input  addr_t        pins_out_base,
  input  addr_t        pins_set_base,
  input  addr_t        pins_in_base,
  input  shift_count_t pins_out_count,
  input  logic [2:0]   pins_set_count,
  input  logic         out_shift_dir,
  input  logic         in_shift_dir,
  input  logic [4:0]   osr_threshold,
  output addr_t        pc,
  output logic         push,
  output logic         pull,
  output word_t        dout,
  output word_t        output_pins,
  output word_t        pin_directions,
  output logic         exec_stalled
);

  logic         tick;
  logic         x_load;
  logic         y_load;
  logic         x_dec;
  logic         y_dec;
  word_t        scratch_value;
  word_t        x;
  word_t        y;
  logic         isr_load;
  logic         isr_shift;
  word_t        isr_value;
  logic         osr_load;
  logic         osr_shift;
  word_t        osr_value;
  word_t        osr;
  word_t        osr_out;
  shift_count_t osr_count;
  logic [4:0]   shift_amount;
  logic         set_pins;
  logic         set_dirs;
  logic         out_pins;
  logic         out_dirs;
  word_t        pin_value;

  pio_clock_divider u_divider (
    .clk     (clk),
    .reset   (reset),
    .en      (en),
    .div_int (div_int),
    .tick    (tick)
  );

  pio_sequencer u_sequencer (
    .clk           (clk),
    .reset         (reset),
    .en            (en),
    .tick          (tick),
    .instr         (instr),
    .input_pins    (input_pins),
    .empty         (empty),
    .full          (full),
    .din           (din),
    .wrap_target   (wrap_target),
    .wrap_top      (wrap_top),
    .jmp_pin       (jmp_pin),
    .pins_in_base  (pins_in_base),
    .osr_threshold (osr_threshold),
    .x             (x),
    .y             (y),
    .isr           (dout),         // RX data is the ISR itself
    .osr           (osr),
    .osr_out       (osr_out),
    .osr_count     (osr_count),
    .pc            (pc),
    .push          (push),
    .pull          (pull),
    .exec_stalled  (exec_stalled),
    .x_load        (x_load),
    .y_load        (y_load),
    .x_dec         (x_dec),
    .y_dec         (y_dec),
    .scratch_value (scratch_value),
    .isr_load      (isr_load),
    .isr_shift     (isr_shift),
    .isr_value     (isr_value),
    .osr_load      (osr_load),
    .osr_shift     (osr_shift),
    .osr_value     (osr_value),
    .shift_amount  (shift_amount),
    .set_pins      (set_pins),
    .set_dirs      (set_dirs),
    .out_pins      (out_pins),
    .out_dirs      (out_dirs),
    .pin_value     (pin_value)
  );

  pio_scratch_regs u_scratch (
    .clk           (clk),
    .reset         (reset),
    .x_load        (x_load),
    .y_load        (y_load),
    .x_dec         (x_dec),
    .y_dec         (y_dec),
    .scratch_value (scratch_value),
    .x             (x),
    .y             (y)
  );

  pio_input_shift u_isr (
    .clk          (clk),
    .reset        (reset),
    .in_shift_dir (in_shift_dir),
    .isr_load     (isr_load),
    .isr_shift    (isr_shift),
    .shift_amount (shift_amount),
    .isr_value    (isr_value),
    .isr          (dout),
    .isr_count    ()              // Only needed with auto-push
  );

  pio_output_shift u_osr (
    .clk           (clk),
    .reset         (reset),
    .out_shift_dir (out_shift_dir),
    .osr_load      (osr_load),
    .osr_shift     (osr_shift),
    .shift_amount  (shift_amount),
    .osr_value     (osr_value),
    .osr           (osr),
    .osr_out       (osr_out),
    .osr_count     (osr_count)
  );

  pio_pin_writer u_pins (
    .clk            (clk),
    .reset          (reset),
    .set_pins       (set_pins),
    .set_dirs       (set_dirs),
    .out_pins       (out_pins),
    .out_dirs       (out_dirs),
    .pin_value      (pin_value),
    .pins_set_base  (pins_set_base),
    .pins_set_count (pins_set_count),
    .pins_out_base  (pins_out_base),
    .pins_out_count (pins_out_count),
    .output_pins    (output_pins),
    .pin_directions (pin_directions)
  );

endmodule

// ==== sim/tb_pio_machine.sv ====
//////////////////////////////////////////////////////////////////////
// PIO state machine testbench
// Program memory, TX and RX FIFO models and directed tests
//////////////////////////////////////////////////////////////////////
module tb_pio_machine import pio_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TEST_CYCLES = 900;   // Rough sum of all test lengths
  localparam int MAX_DIV     = 3;
  localparam int MARGIN      = 2000;

  logic clk, reset, en, empty, full, out_shift_dir, in_shift_dir;
  logic [15:0] div_int;
  instr_t instr;
  word_t din, input_pins, dout, output_pins, pin_directions;
  addr_t wrap_target, wrap_top, jmp_pin, pins_out_base, pins_set_base, pins_in_base, pc;
  shift_count_t pins_out_count;
  logic [2:0] pins_set_count;
  logic [4:0] osr_threshold;
  logic push, pull, exec_stalled;

  instr_t program_mem [32];
  word_t  tx_fifo[$];
  word_t  rx_fifo[$];
  logic   pull_pending;
  int     pull_count;
  int     push_count;

  pio_machine i_dut (.*);

  assign instr = program_mem[pc];  // Program memory read

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  initial begin
    #((TEST_CYCLES * MAX_DIV + MARGIN) * 20);
    report_failure("timeout: the tests did not complete in time");
  end

  // TX FIFO pops one clock after a pull strobe, RX FIFO stores dout at push
  initial begin
    pull_pending = 1'b0;
    forever begin
      @(negedge clk);
      if (pull_pending && tx_fifo.size() > 0) void'(tx_fifo.pop_front());
      empty = (tx_fifo.size() == 0);
      din   = empty ? '0 : tx_fifo[0];
      #1;
      pull_pending = pull;
      if (pull) pull_count++;
      if (push) begin
        rx_fifo.push_back(dout);
        push_count++;
      end
    end
  end

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
  endtask

  function automatic instr_t encode_instr(opcode_e op, logic [4:0] dly, logic [2:0] op1,
                                          logic [4:0] op2);
    return {op, dly, op1, op2};
  endfunction

  function automatic word_t reverse_bits(word_t value);
    word_t r;
    for (int i = 0; i < 32; i++) r[i] = value[31-i];
    return r;
  endfunction

  function automatic word_t rotate_down(word_t value, int base);
    word_t r;
    for (int i = 0; i < 32; i++) r[i] = value[(i + base) % 32];
    return r;
  endfunction

  function automatic word_t write_window(word_t old, word_t value, int base, int count);
    word_t r;
    r = old;
    for (int i = 0; i < count; i++) r[(base + i) % 32] = value[i];
    return r;
  endfunction

  // Every unused address jumps to itself
  task automatic clear_program();
    for (int i = 0; i < 32; i++) program_mem[i] = encode_instr(op_jmp, 5'd0, 3'd0, 5'(i));
    tx_fifo.delete();
    rx_fifo.delete();
  endtask

  task automatic reset_dut();
    @(negedge clk);
    reset = 1'b1;
    en    = 1'b0;
    pull_count = 0;
    push_count = 0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    en    = 1'b1;
  endtask

  task automatic wait_pc(addr_t target, int limit, output int cycles);
    cycles = 0;
    while (pc !== target) begin
      if (cycles >= limit) report_failure($sformatf("pc did not reach %0d in time", target));
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic test_set_mov();
    logic [4:0] v;
    logic [4:0] w;
    int cyc;
    v = 5'($urandom_range(31, 1));
    w = 5'($urandom_range(31, 24));  // Top bits fall outside the SET window
    clear_program();
    pins_out_count = 6'd32;
    pins_set_base  = 5'd30;
    pins_set_count = 3'd3;
    program_mem[0] = encode_instr(op_set, 5'd0, 3'd1, v);         // SET X
    program_mem[1] = encode_instr(op_mov, 5'd0, 3'd2, 5'b01_001);  // MOV Y, ~X
    program_mem[2] = encode_instr(op_mov, 5'd0, 3'd0, 5'b10_010);  // MOV PINS, ::Y
    program_mem[3] = encode_instr(op_set, 5'd0, 3'd4, w);          // SET PINDIRS
    reset_dut();
    wait_pc(5'd4, 20, cyc);
    check_word("output_pins", output_pins, reverse_bits(~{27'b0, v}));
    check_word("pin_directions", pin_directions, write_window('0, {27'b0, w}, 30, 3));
  endtask

  task automatic test_jmp_wrap();
    addr_t expected[$];
    int n;
    n = $urandom_range(6, 2);
    clear_program();
    wrap_target = 5'd2;
    wrap_top    = 5'd3;
    program_mem[0] = encode_instr(op_set, 5'd0, 3'd1, 5'(n));
    program_mem[1] = encode_instr(op_jmp, 5'd0, 3'd2, 5'd1);       // JMP X-- 1
    program_mem[2] = encode_instr(op_mov, 5'd0, 3'd2, 5'b00_010);  // MOV Y, Y
    program_mem[3] = encode_instr(op_mov, 5'd0, 3'd2, 5'b00_010);
    expected.push_back(5'd0);
    for (int i = 0; i <= n; i++) expected.push_back(5'd1);
    repeat (3) begin
      expected.push_back(5'd2);
      expected.push_back(5'd3);
    end
    reset_dut();
    foreach (expected[i]) begin
      check_addr("pc", pc, expected[i]);
      @(negedge clk);
    end
    wrap_target = 5'd0;
    wrap_top    = 5'd31;
  endtask

  task automatic test_pull_out();
    word_t words[3];
    int cyc;
    for (int i = 0; i < 3; i++) words[i] = $urandom();
    clear_program();
    out_shift_dir  = 1'b1;
    pins_out_base  = 5'd0;
    pins_out_count = 6'd8;
    program_mem[0] = encode_instr(op_push_pull, 5'd0, 3'b101, 5'd0);  // PULL block
    for (int i = 1; i <= 4; i++) program_mem[i] = encode_instr(op_out, 5'd0, 3'd0, 5'd8);
    program_mem[5] = encode_instr(op_jmp, 5'd0, 3'd0, 5'd0);
    tx_fifo.push_back(words[0]);
    tx_fifo.push_back(words[1]);
    reset_dut();
    for (int k = 0; k < 2; k++) begin
      for (int b = 0; b < 4; b++) begin
        wait_pc(5'(b + 2), 40, cyc);
        check_word("output_pins", output_pins, {24'b0, words[k][8*b +: 8]});
      end
      check_word("pull_count", word_t'(pull_count), word_t'(k + 1));
    end
    wait_pc(5'd0, 20, cyc);
    repeat (2) @(negedge clk);
    repeat (8) begin
      check_addr("pc", pc, 5'd0);
      check_bit("exec_stalled", exec_stalled, 1'b1);
      @(negedge clk);
    end
    tx_fifo.push_back(words[2]);
    wait_pc(5'd2, 20, cyc);
    check_word("output_pins", output_pins, {24'b0, words[2][7:0]});
    check_bit("exec_stalled", exec_stalled, 1'b0);

    // Non-blocking PULL on an empty FIFO takes X
    clear_program();
    pins_out_count = 6'd32;
    program_mem[0] = encode_instr(op_set, 5'd0, 3'd1, 5'd19);
    program_mem[1] = encode_instr(op_push_pull, 5'd0, 3'b100, 5'd0);
    program_mem[2] = encode_instr(op_out, 5'd0, 3'd0, 5'd0);          // OUT PINS 32
    reset_dut();
    wait_pc(5'd3, 20, cyc);
    check_word("output_pins", output_pins, 32'd19);
    check_word("pull_count", word_t'(pull_count), '0);
  endtask

  task automatic test_in_push();
    word_t r;
    int cyc;
    r = $urandom();
    clear_program();
    input_pins   = r;
    pins_in_base = 5'd5;
    program_mem[0] = encode_instr(op_in, 5'd0, 3'd0, 5'd0);           // IN PINS 32
    program_mem[1] = encode_instr(op_push_pull, 5'd0, 3'b001, 5'd0);  // PUSH block
    reset_dut();
    wait_pc(5'd2, 20, cyc);
    check_word("push_count", word_t'(push_count), 32'd1);
    check_word("dout", rx_fifo[0], rotate_down(r, 5));

    rx_fifo.delete();
    full = 1'b1;
    reset_dut();
    wait_pc(5'd1, 20, cyc);
    repeat (2) @(negedge clk);
    repeat (6) begin
      check_addr("pc", pc, 5'd1);
      check_bit("exec_stalled", exec_stalled, 1'b1);
      check_word("push_count", word_t'(push_count), '0);
      @(negedge clk);
    end
    full = 1'b0;
    wait_pc(5'd2, 20, cyc);
    check_word("dout", rx_fifo[0], rotate_down(r, 5));
    pins_in_base = 5'd0;
  endtask

  task automatic test_wait();
    int k;
    k = $urandom_range(31, 0);
    clear_program();
    input_pins = '0;
    program_mem[0] = encode_instr(op_wait, 5'd0, 3'b100, 5'(k));  // WAIT 1 GPIO k
    reset_dut();
    repeat (8) begin
      check_addr("pc", pc, 5'd0);
      @(negedge clk);
    end
    input_pins[k] = 1'b1;
    @(negedge clk);
    check_addr("pc", pc, 5'd1);
  endtask

  task automatic test_divider_delay();
    int cyc;
    int d;
    d = 4;
    clear_program();
    div_int = 16'(MAX_DIV);
    for (int i = 0; i < 4; i++) begin
      program_mem[i] = encode_instr(op_mov, (i == 2) ? 5'(d) : 5'd0, 3'd2, 5'b00_010);
    end
    reset_dut();
    wait_pc(5'd1, 20, cyc);
    wait_pc(5'd2, 20, cyc);
    check_word("pc interval", word_t'(cyc), word_t'(MAX_DIV));
    wait_pc(5'd3, 20, cyc);
    check_word("pc interval", word_t'(cyc), word_t'(MAX_DIV));
    wait_pc(5'd4, 40, cyc);
    check_word("delay interval", word_t'(cyc), word_t'((d + 1) * MAX_DIV));
  endtask

  initial begin
    pull_count     = 0;
    push_count     = 0;
    reset          = 1'b1;
    en             = 1'b0;
    div_int        = 16'd1;
    din            = '0;
    empty          = 1'b1;
    full           = 1'b0;
    input_pins     = '0;
    wrap_target    = 5'd0;
    wrap_top       = 5'd31;
    jmp_pin        = 5'd0;
    pins_out_base  = 5'd0;
    pins_set_base  = 5'd0;
    pins_in_base   = 5'd0;
    pins_out_count = 6'd32;
    pins_set_count = 3'd5;
    out_shift_dir  = 1'b1;
    in_shift_dir   = 1'b0;
    osr_threshold  = 5'd0;
    clear_program();
    void'($urandom(32'hbbe5a4ad));
    test_set_mov();
    test_jmp_wrap();
    test_pull_out();
    test_in_push();
    test_wait();
    test_divider_delay();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== pio_machine.f ====
source/pio_pkg.sv
source/pio_clock_divider.sv
source/pio_sequencer.sv
source/pio_scratch_regs.sv
source/pio_input_shift.sv
source/pio_output_shift.sv
source/pio_pin_writer.sv
source/pio_machine.sv
sim/tb_pio_machine.sv
